//--- rtl/beam_pkg.sv
package beam_pkg;

    // --------------------------------------------------
    // Pipeline latencies
    // --------------------------------------------------

    // Product, antenna tree, output register
    localparam int MAC_ANTS_LAT  = 3;
    // Per-phase MAC plus even/odd add and output register
    localparam int MAC_BEAMS_LAT = MAC_ANTS_LAT + 2;
    // Saturation register in the output side
    localparam int OUT_STAGE_LAT = 1;

    // --------------------------------------------------
    // Code word write port
    // --------------------------------------------------

    // Width of the weight field in a write
    localparam int CW_VALUE_W = 32;

    // Beam or antenna index of a write
    typedef logic [7:0] cw_idx_t;

    // One weight write
    // Low IW bits of value carry the weight, real part in their upper half
    typedef struct packed {
        logic                  en;
        logic                  odd;
        cw_idx_t               beam;
        cw_idx_t               ant;
        logic [CW_VALUE_W-1:0] value;
    } cw_wr_t;

    // --------------------------------------------------
    // Overflow flags
    // --------------------------------------------------

    // Bit positions inside sat_flag_t
    localparam int SAT_SUM  = 2;
    localparam int SAT_EVEN = 1;
    localparam int SAT_ODD  = 0;

    // Per-beam overflow: sum, even, odd
    typedef logic [2:0] sat_flag_t;

endpackage

//--- rtl/snapshot_pairer.sv
`timescale 1ns/1ps

module snapshot_pairer #(
    parameter int ANT = 4,
    parameter int IW  = 16
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [ANT*IW-1:0] i_ant_data,
    input  logic              i_ant_valid,
    output logic [ANT*IW-1:0] o_even,
    output logic [ANT*IW-1:0] o_odd,
    output logic              o_pair_valid
);

    // High while an even snapshot waits for its odd partner
    logic              phase;
    // Pending even snapshot
    logic [ANT*IW-1:0] even_hold;
    // Odd snapshot accepted this cycle
    logic              odd_take;

    assign odd_take = i_ant_valid & phase;

    // --------------------------------------------------
    // Phase control
    // --------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase        <= 1'b0;
            o_pair_valid <= 1'b0;
        end else begin
            // Valid gap drops back to even, discarding the held snapshot
            phase        <= i_ant_valid & ~phase;
            // One cycle after the odd snapshot
            o_pair_valid <= odd_take;
        end
    end

    // --------------------------------------------------
    // Snapshot capture
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_ant_valid && !phase) begin
            even_hold <= i_ant_data;
        end
        // Both phases presented together with the pulse
        if (odd_take) begin
            o_even <= even_hold;
            o_odd  <= i_ant_data;
        end
    end

    // Pairs are at least two snapshots apart
    property p_pair_pulse;
        @(posedge i_clk) disable iff (!i_rst_n)
        o_pair_valid |=> !o_pair_valid;
    endproperty
    a_pair_pulse: assert property (p_pair_pulse)
        else $error("pair_valid held high for two cycles");

endmodule

//--- rtl/codeword_bank.sv
`timescale 1ns/1ps

module codeword_bank #(
    parameter int BEAM = 2,
    parameter int ANT  = 4,
    parameter int IW   = 16
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  beam_pkg::cw_wr_t                 i_cw_wr,
    output logic [BEAM-1:0][ANT*IW-1:0]      o_cw_even,
    output logic [BEAM-1:0][ANT*IW-1:0]      o_cw_odd
);

    // Weight storage, one word per beam and antenna
    logic [BEAM-1:0][ANT*IW-1:0] cw_even;
    logic [BEAM-1:0][ANT*IW-1:0] cw_odd;
    // Weight taken from the write, real part high
    logic [IW-1:0]               wr_value;

    assign wr_value = i_cw_wr.value[IW-1:0];

    // --------------------------------------------------
    // Write decode
    // --------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            // All weights zero after reset
            cw_even <= '0;
            cw_odd  <= '0;
        end else if (i_cw_wr.en) begin
            for (int b = 0; b < BEAM; b++) begin
                for (int a = 0; a < ANT; a++) begin
                    // Beam and antenna match selects one word
                    if (i_cw_wr.beam == beam_pkg::cw_idx_t'(b) &&
                        i_cw_wr.ant == beam_pkg::cw_idx_t'(a)) begin
                        if (i_cw_wr.odd) begin
                            cw_odd[b][a*IW +: IW] <= wr_value;
                        end else begin
                            cw_even[b][a*IW +: IW] <= wr_value;
                        end
                    end
                end
            end
        end
    end

    // All words visible in parallel
    assign o_cw_even = cw_even;
    assign o_cw_odd  = cw_odd;

    // Out-of-range writes would be silently lost
    property p_wr_range;
        @(posedge i_clk) disable iff (!i_rst_n)
        i_cw_wr.en |-> (int'(i_cw_wr.beam) < BEAM) && (int'(i_cw_wr.ant) < ANT);
    endproperty
    a_wr_range: assert property (p_wr_range)
        else $error("code word write outside the beam or antenna range");

endmodule

//--- rtl/mac_ants.sv
`timescale 1ns/1ps

module mac_ants #(
    parameter int ANT = 4,
    parameter int IW  = 16,
    parameter int OW  = 24
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [ANT*IW-1:0] i_ants_data,
    input  logic              i_rvalid,
    input  logic [ANT*IW-1:0] i_code_word,
    output logic [2*OW-1:0]   o_sum_data,
    output logic              o_valid
);

    // Half width, one real or imaginary part
    localparam int HW = IW / 2;
    // Product width, one growth bit for the add
    localparam int PW = IW + 1;

    // Stage 1 products, real high
    logic [ANT-1:0][2*PW-1:0]         prod;
    // Antenna sums before the register
    logic signed [OW-1:0]             tree_re;
    logic signed [OW-1:0]             tree_im;
    // Stage 2 registers
    logic [OW-1:0]                    acc_re;
    logic [OW-1:0]                    acc_im;
    // Valid alongside the three stages
    logic [beam_pkg::MAC_ANTS_LAT-1:0] vld_sr;

    // Complex product (a + jb)(c + jd)
    function automatic logic [2*PW-1:0] cmul(
        input logic [IW-1:0] x,
        input logic [IW-1:0] w
    );
        logic signed [PW-1:0] a;
        logic signed [PW-1:0] b;
        logic signed [PW-1:0] c;
        logic signed [PW-1:0] d;
        a = $signed(x[IW-1:HW]);
        b = $signed(x[HW-1:0]);
        c = $signed(w[IW-1:HW]);
        d = $signed(w[HW-1:0]);
        cmul = {a * c - b * d, a * d + b * c};
    endfunction

    // --------------------------------------------------
    // Stage 1: per-antenna products
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        for (int k = 0; k < ANT; k++) begin
            prod[k] <= cmul(i_ants_data[k*IW +: IW], i_code_word[k*IW +: IW]);
        end
    end

    // --------------------------------------------------
    // Stage 2: sum over antennas
    // --------------------------------------------------

    always_comb begin
        tree_re = '0;
        tree_im = '0;
        for (int k = 0; k < ANT; k++) begin
            // Sign extension to accumulator width
            tree_re = tree_re + OW'($signed(prod[k][2*PW-1:PW]));
            tree_im = tree_im + OW'($signed(prod[k][PW-1:0]));
        end
    end

    always_ff @(posedge i_clk) begin
        acc_re <= tree_re;
        acc_im <= tree_im;
    end

    // --------------------------------------------------
    // Stage 3: output register
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        o_sum_data <= {acc_re, acc_im};
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[beam_pkg::MAC_ANTS_LAT-2:0], i_rvalid};
        end
    end

    assign o_valid = vld_sr[beam_pkg::MAC_ANTS_LAT-1];

    // Accumulator must hold the full antenna sum
    if (OW < IW + 1 + $clog2(ANT)) begin : g_width_check
        $error("OW too narrow for IW and ANT growth");
    end

endmodule

//--- rtl/mac_beams.sv
`timescale 1ns/1ps

module mac_beams #(
    parameter int BEAM = 2,
    parameter int ANT  = 4,
    parameter int IW   = 16,
    parameter int OW   = 24
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic [ANT*IW-1:0]           i_ants_data_even,
    input  logic [ANT*IW-1:0]           i_ants_data_odd,
    input  logic                        i_rvalid,
    input  logic [BEAM-1:0][ANT*IW-1:0] i_code_word_even,
    input  logic [BEAM-1:0][ANT*IW-1:0] i_code_word_odd,
    output logic [BEAM-1:0][2*OW-1:0]   o_sum_data_even,
    output logic [BEAM-1:0][2*OW-1:0]   o_sum_data_odd,
    output logic [BEAM-1:0][2*OW-1:0]   o_sum_data,
    output logic                        o_valid
);

    // Registered code words
    logic [BEAM-1:0][ANT*IW-1:0] code_word_even;
    logic [BEAM-1:0][ANT*IW-1:0] code_word_odd;
    // Per-phase MAC results
    logic [BEAM-1:0][2*OW-1:0]   even_sum;
    logic [BEAM-1:0][2*OW-1:0]   odd_sum;
    logic [BEAM-1:0]             even_vld;
    logic [BEAM-1:0]             odd_vld;
    // Even/odd add stage
    logic [BEAM-1:0][2*OW-1:0]   pair_sum;
    logic [BEAM-1:0][2*OW-1:0]   even_d;
    logic [BEAM-1:0][2*OW-1:0]   odd_d;
    logic [1:0]                  vld_sr;

    // --------------------------------------------------
    // Input register
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        code_word_even <= i_code_word_even;
        code_word_odd  <= i_code_word_odd;
    end

    // --------------------------------------------------
    // Even and odd MAC per beam
    // --------------------------------------------------

    for (genvar bi = 0; bi < BEAM; bi++) begin : g_beam
        mac_ants #(
            .ANT (ANT),
            .IW  (IW),
            .OW  (OW)
        ) u_mac_even (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_ants_data (i_ants_data_even),
            .i_rvalid    (i_rvalid),
            .i_code_word (code_word_even[bi]),
            .o_sum_data  (even_sum[bi]),
            .o_valid     (even_vld[bi])
        );

        mac_ants #(
            .ANT (ANT),
            .IW  (IW),
            .OW  (OW)
        ) u_mac_odd (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_ants_data (i_ants_data_odd),
            .i_rvalid    (i_rvalid),
            .i_code_word (code_word_odd[bi]),
            .o_sum_data  (odd_sum[bi]),
            .o_valid     (odd_vld[bi])
        );
    end

    // --------------------------------------------------
    // Even + odd sum and output register
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        for (int k = 0; k < BEAM; k++) begin
            // Wraps in OW bits per part
            pair_sum[k][2*OW-1:OW] <= even_sum[k][2*OW-1:OW] + odd_sum[k][2*OW-1:OW];
            pair_sum[k][OW-1:0]    <= even_sum[k][OW-1:0] + odd_sum[k][OW-1:0];
        end
        // Phase results delayed to line up with the sum
        even_d          <= even_sum;
        odd_d           <= odd_sum;
        o_sum_data      <= pair_sum;
        o_sum_data_even <= even_d;
        o_sum_data_odd  <= odd_d;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_sr <= '0;
        end else begin
            // All MAC instances share one valid
            vld_sr <= {vld_sr[0], (&even_vld) & (&odd_vld)};
        end
    end

    assign o_valid = vld_sr[1];

endmodule

//--- rtl/beam_output_stage.sv
`timescale 1ns/1ps

module beam_output_stage #(
    parameter int BEAM = 2,
    parameter int OW   = 24,
    parameter int QW   = 12
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic [BEAM-1:0][2*OW-1:0]           i_sum,
    input  logic [BEAM-1:0][2*OW-1:0]           i_even,
    input  logic [BEAM-1:0][2*OW-1:0]           i_odd,
    input  logic                                i_valid,
    input  logic                                i_sat_clear,
    output logic [BEAM-1:0][2*QW-1:0]           o_sum,
    output logic [BEAM-1:0][2*QW-1:0]           o_even,
    output logic [BEAM-1:0][2*QW-1:0]           o_odd,
    output logic                                o_valid,
    output beam_pkg::sat_flag_t [BEAM-1:0]      o_sat
);

    // Saturated results and their overflow bits
    logic [BEAM-1:0][2*QW-1:0]         sum_q;
    logic [BEAM-1:0][2*QW-1:0]         even_q;
    logic [BEAM-1:0][2*QW-1:0]         odd_q;
    beam_pkg::sat_flag_t [BEAM-1:0]    ovf;

    // One part to QW bits, overflow flag on top
    function automatic logic [QW:0] sat_part(input logic [OW-1:0] x);
        logic ovf_bit;
        ovf_bit = (x[OW-1:QW-1] != {(OW-QW+1){x[OW-1]}});
        if (!ovf_bit) begin
            sat_part = {1'b0, x[QW-1:0]};
        end else if (x[OW-1]) begin
            sat_part = {1'b1, 1'b1, {(QW-1){1'b0}}};
        end else begin
            sat_part = {1'b1, 1'b0, {(QW-1){1'b1}}};
        end
    endfunction

    // Complex value, overflow if either part clips
    function automatic logic [2*QW:0] sat_cplx(input logic [2*OW-1:0] x);
        logic [QW:0] re;
        logic [QW:0] im;
        re = sat_part(x[2*OW-1:OW]);
        im = sat_part(x[OW-1:0]);
        sat_cplx = {re[QW] | im[QW], re[QW-1:0], im[QW-1:0]};
    endfunction

    // --------------------------------------------------
    // Saturation
    // --------------------------------------------------

    always_comb begin
        for (int k = 0; k < BEAM; k++) begin
            {ovf[k][beam_pkg::SAT_SUM],  sum_q[k]}  = sat_cplx(i_sum[k]);
            {ovf[k][beam_pkg::SAT_EVEN], even_q[k]} = sat_cplx(i_even[k]);
            {ovf[k][beam_pkg::SAT_ODD],  odd_q[k]}  = sat_cplx(i_odd[k]);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_sum  <= sum_q;
            o_even <= even_q;
            o_odd  <= odd_q;
        end
    end

    // --------------------------------------------------
    // Valid and sticky flags
    // --------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_sat   <= '0;
        end else begin
            o_valid <= i_valid;
            // New overflow wins over a same-cycle clear
            o_sat   <= (i_sat_clear ? '0 : o_sat) | (i_valid ? ovf : '0);
        end
    end

    // Flags move only on a result or a clear
    property p_sat_stable;
        @(posedge i_clk) disable iff (!i_rst_n)
        !$past(i_valid, beam_pkg::OUT_STAGE_LAT) && !$past(i_sat_clear) |-> $stable(o_sat);
    endproperty
    a_sat_stable: assert property (p_sat_stable)
        else $error("o_sat changed without a valid or a clear");

endmodule

//--- rtl/beamformer_top.sv
`timescale 1ns/1ps

module beamformer_top #(
    parameter int BEAM = 2,
    parameter int ANT  = 4,
    parameter int IW   = 16,
    parameter int OW   = 24,
    parameter int QW   = 12
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic [ANT*IW-1:0]              i_ant_data,
    input  logic                           i_ant_valid,
    input  beam_pkg::cw_wr_t               i_cw_wr,
    input  logic                           i_sat_clear,
    output logic [BEAM-1:0][2*QW-1:0]      o_sum,
    output logic [BEAM-1:0][2*QW-1:0]      o_even,
    output logic [BEAM-1:0][2*QW-1:0]      o_odd,
    output logic                           o_valid,
    output beam_pkg::sat_flag_t [BEAM-1:0] o_sat
);

    // Paired snapshots
    logic [ANT*IW-1:0]           snap_even;
    logic [ANT*IW-1:0]           snap_odd;
    logic                        pair_valid;
    // Weights
    logic [BEAM-1:0][ANT*IW-1:0] cw_even;
    logic [BEAM-1:0][ANT*IW-1:0] cw_odd;
    // Full-width beam results
    logic [BEAM-1:0][2*OW-1:0]   mac_sum;
    logic [BEAM-1:0][2*OW-1:0]   mac_even;
    logic [BEAM-1:0][2*OW-1:0]   mac_odd;
    logic                        mac_valid;

    // --------------------------------------------------
    // Input side
    // --------------------------------------------------

    snapshot_pairer #(
        .ANT (ANT),
        .IW  (IW)
    ) u_pairer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_ant_data   (i_ant_data),
        .i_ant_valid  (i_ant_valid),
        .o_even       (snap_even),
        .o_odd        (snap_odd),
        .o_pair_valid (pair_valid)
    );

    codeword_bank #(
        .BEAM (BEAM),
        .ANT  (ANT),
        .IW   (IW)
    ) u_bank (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_cw_wr   (i_cw_wr),
        .o_cw_even (cw_even),
        .o_cw_odd  (cw_odd)
    );

    // --------------------------------------------------
    // Processing and output side
    // --------------------------------------------------

    mac_beams #(
        .BEAM (BEAM),
        .ANT  (ANT),
        .IW   (IW),
        .OW   (OW)
    ) u_mac_beams (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_ants_data_even (snap_even),
        .i_ants_data_odd  (snap_odd),
        .i_rvalid         (pair_valid),
        .i_code_word_even (cw_even),
        .i_code_word_odd  (cw_odd),
        .o_sum_data_even  (mac_even),
        .o_sum_data_odd   (mac_odd),
        .o_sum_data       (mac_sum),
        .o_valid          (mac_valid)
    );

    beam_output_stage #(
        .BEAM (BEAM),
        .OW   (OW),
        .QW   (QW)
    ) u_out (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_sum       (mac_sum),
        .i_even      (mac_even),
        .i_odd       (mac_odd),
        .i_valid     (mac_valid),
        .i_sat_clear (i_sat_clear),
        .o_sum       (o_sum),
        .o_even      (o_even),
        .o_odd       (o_odd),
        .o_valid     (o_valid),
        .o_sat       (o_sat)
    );

endmodule

//--- verification/beamformer_tb.sv
`timescale 1ns/1ps

module beamformer_tb;

    localparam int BEAM = 2;
    localparam int ANT  = 4;
    localparam int IW   = 16;
    localparam int OW   = 24;
    localparam int QW   = 12;
    localparam int HW   = IW / 2;
    // Odd snapshot to o_valid, plus one for the negedge counter lag
    localparam int OUT_DELAY = 1 + beam_pkg::MAC_BEAMS_LAT + beam_pkg::OUT_STAGE_LAT + 1;
    // Full-scale weights and samples, real part only
    localparam logic [IW-1:0] W_FULL = {1'b0, {(HW-1){1'b1}}, {HW{1'b0}}};
    localparam logic [IW-1:0] W_NEG  = {1'b1, {(HW-1){1'b0}}, {HW{1'b0}}};

    // One expected beam result set
    typedef struct packed {
        logic [BEAM-1:0][2*QW-1:0]      sum;
        logic [BEAM-1:0][2*QW-1:0]      even;
        logic [BEAM-1:0][2*QW-1:0]      odd;
        beam_pkg::sat_flag_t [BEAM-1:0] ovf;
        int                             due;
    } result_t;

    logic                           i_clk;
    logic                           i_rst_n;
    logic [ANT*IW-1:0]              i_ant_data;
    logic                           i_ant_valid;
    beam_pkg::cw_wr_t               i_cw_wr;
    logic                           i_sat_clear;
    logic [BEAM-1:0][2*QW-1:0]      o_sum;
    logic [BEAM-1:0][2*QW-1:0]      o_even;
    logic [BEAM-1:0][2*QW-1:0]      o_odd;
    logic                           o_valid;
    beam_pkg::sat_flag_t [BEAM-1:0] o_sat;

    // Reference model state
    logic [31:0]                    lfsr;
    logic [IW-1:0]                  w_even [BEAM][ANT];
    logic [IW-1:0]                  w_odd  [BEAM][ANT];
    result_t                        exp_q [$];
    result_t                        head;
    logic                           head_have = 1'b0;
    beam_pkg::sat_flag_t [BEAM-1:0] exp_sat = '0;
    logic                           clr_prev = 1'b0;
    logic                           model_phase;
    logic [ANT*IW-1:0]              pend_even;
    int                             cyc = 0;
    int                             n_pairs = 0;
    int                             n_out = 0;

    beamformer_top #(
        .BEAM (BEAM),
        .ANT  (ANT),
        .IW   (IW),
        .OW   (OW),
        .QW   (QW)
    ) DUT (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ant_data  (i_ant_data),
        .i_ant_valid (i_ant_valid),
        .i_cw_wr     (i_cw_wr),
        .i_sat_clear (i_sat_clear),
        .o_sum       (o_sum),
        .o_even      (o_even),
        .o_odd       (o_odd),
        .o_valid     (o_valid),
        .o_sat       (o_sat)
    );

    always #10 i_clk = ~i_clk;

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        abort_run();
    endtask

    // --------------------------------------------------
    // Stimulus LFSR
    // --------------------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // Small complex word, each part in -8..7
    task automatic rand_word(output logic [IW-1:0] v);
        logic [31:0] re;
        logic [31:0] im;
        take_bits(4, re);
        take_bits(4, im);
        v = {{(HW-4){re[3]}}, re[3:0], {(HW-4){im[3]}}, im[3:0]};
    endtask

    task automatic rand_snapshot(output logic [ANT*IW-1:0] x);
        logic [IW-1:0] v;
        int            a;
        for (a = 0; a < ANT; a++) begin
            rand_word(v);
            x[a*IW +: IW] = v;
        end
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Signed real (hi) or imaginary half
    function automatic int part(input logic [IW-1:0] x, input bit hi);
        logic signed [HW-1:0] p;
        p    = hi ? x[IW-1:HW] : x[HW-1:0];
        part = int'(p);
    endfunction

    // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
    function automatic int mul_re(input logic [IW-1:0] x, input logic [IW-1:0] w);
        mul_re = part(x, 1'b1) * part(w, 1'b1) - part(x, 1'b0) * part(w, 1'b0);
    endfunction

    function automatic int mul_im(input logic [IW-1:0] x, input logic [IW-1:0] w);
        mul_im = part(x, 1'b1) * part(w, 1'b0) + part(x, 1'b0) * part(w, 1'b1);
    endfunction

    // Clamp to QW bits, clip flag on top
    function automatic logic [QW:0] clip(input int x);
        int lim;
        lim = (1 << (QW - 1)) - 1;
        if (x > lim) begin
            clip = {1'b1, QW'(lim)};
        end else if (x < -lim - 1) begin
            clip = {1'b1, QW'(-lim - 1)};
        end else begin
            clip = {1'b0, QW'(x)};
        end
    endfunction

    // Overflow if either part clips
    function automatic logic [2*QW:0] quantize(input int re, input int im);
        logic [QW:0] q_re;
        logic [QW:0] q_im;
        q_re     = clip(re);
        q_im     = clip(im);
        quantize = {q_re[QW] | q_im[QW], q_re[QW-1:0], q_im[QW-1:0]};
    endfunction

    task automatic push_expected(input logic [ANT*IW-1:0] xe, input logic [ANT*IW-1:0] xo);
        result_t r;
        int      er;
        int      ei;
        int      orr;
        int      oi;
        int      b;
        int      a;
        r = '0;
        for (b = 0; b < BEAM; b++) begin
            er  = 0;
            ei  = 0;
            orr = 0;
            oi  = 0;
            for (a = 0; a < ANT; a++) begin
                er  += mul_re(xe[a*IW +: IW], w_even[b][a]);
                ei  += mul_im(xe[a*IW +: IW], w_even[b][a]);
                orr += mul_re(xo[a*IW +: IW], w_odd[b][a]);
                oi  += mul_im(xo[a*IW +: IW], w_odd[b][a]);
            end
            {r.ovf[b][beam_pkg::SAT_EVEN], r.even[b]} = quantize(er, ei);
            {r.ovf[b][beam_pkg::SAT_ODD], r.odd[b]}   = quantize(orr, oi);
            // Phase sum taken at full width, then clipped
            {r.ovf[b][beam_pkg::SAT_SUM], r.sum[b]}   = quantize(er + orr, ei + oi);
        end
        r.due = cyc + OUT_DELAY;
        exp_q.push_back(r);
        n_pairs++;
    endtask

    // --------------------------------------------------
    // Drivers
    // --------------------------------------------------

    task automatic send(input logic v, input logic [ANT*IW-1:0] x);
        @(posedge i_clk);
        i_ant_valid <= v;
        i_ant_data  <= x;
        i_cw_wr.en  <= 1'b0;
        i_sat_clear <= 1'b0;
        // Gap drops a held even snapshot
        if (!v) begin
            model_phase = 1'b0;
        end else if (!model_phase) begin
            pend_even   = x;
            model_phase = 1'b1;
        end else begin
            push_expected(pend_even, x);
            model_phase = 1'b0;
        end
    endtask

    task automatic write_weight(input bit odd, input int b, input int a, input logic [IW-1:0] v);
        beam_pkg::cw_wr_t w;
        w.en    = 1'b1;
        w.odd   = odd;
        w.beam  = beam_pkg::cw_idx_t'(b);
        w.ant   = beam_pkg::cw_idx_t'(a);
        w.value = {{(beam_pkg::CW_VALUE_W - IW){1'b0}}, v};
        @(posedge i_clk);
        i_cw_wr     <= w;
        i_ant_valid <= 1'b0;
        model_phase = 1'b0;
        if (odd) begin
            w_odd[b][a] = v;
        end else begin
            w_even[b][a] = v;
        end
    endtask

    task automatic clear_sat();
        @(posedge i_clk);
        i_sat_clear <= 1'b1;
        i_ant_valid <= 1'b0;
        i_cw_wr.en  <= 1'b0;
        model_phase = 1'b0;
    endtask

    task automatic wait_results();
        int t;
        t = 0;
        while (n_out != n_pairs && t < 100) begin
            @(posedge i_clk);
            t++;
        end
        if (n_out != n_pairs) begin
            $display("Timed out after %0d cycles waiting for %0d beam results",
                     t, n_pairs - n_out);
            abort_run();
        end
    endtask

    // --------------------------------------------------
    // Result tracking, between clock edges
    // --------------------------------------------------

    always @(negedge i_clk) begin
        cyc = cyc + 1;
        if (!i_rst_n) begin
            head_have = 1'b0;
            exp_sat   = '0;
            clr_prev  = 1'b0;
        end else begin
            // A clear lands on the edge after it is driven
            if (clr_prev) begin
                exp_sat = '0;
            end
            head_have = 1'b0;
            if (o_valid && exp_q.size() > 0) begin
                head      = exp_q.pop_front();
                head_have = 1'b1;
                exp_sat   = exp_sat | head.ovf;
            end
            if (o_valid) begin
                n_out++;
            end
            clr_prev = i_sat_clear;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    a_reset_idle: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !o_valid && o_sat == '0)
        else report_error("o_valid or o_sat not low after reset");

    a_expected: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_valid |-> head_have)
        else report_error("o_valid with no pair outstanding");

    a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> head.due == cyc)
        else report_error($sformatf("o_valid at cycle %0d, expected %0d", cyc, head.due));

    a_sum: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_valid |-> o_sum == head.sum)
        else report_error($sformatf("o_sum %h, expected %h", o_sum, head.sum));

    a_even: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> o_even == head.even)
        else report_error($sformatf("o_even %h, expected %h", o_even, head.even));

    a_odd: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_valid |-> o_odd == head.odd)
        else report_error($sformatf("o_odd %h, expected %h", o_odd, head.odd));

    // Sticky flags checked every cycle
    a_sat: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_sat == exp_sat)
        else report_error($sformatf("o_sat %b, expected %b", o_sat, exp_sat));

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        logic [ANT*IW-1:0] xe;
        logic [IW-1:0]     w;
        int                b;
        int                a;
        int                k;
        i_clk       = 1'b0;
        i_rst_n     = 1'b0;
        i_ant_data  = '0;
        i_ant_valid = 1'b0;
        i_cw_wr     = '0;
        i_sat_clear = 1'b0;
        lfsr        = 32'hacaf646a;
        model_phase = 1'b0;
        pend_even   = '0;
        for (b = 0; b < BEAM; b++) begin
            for (a = 0; a < ANT; a++) begin
                w_even[b][a] = '0;
                w_odd[b][a]  = '0;
            end
        end
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (2) @(posedge i_clk);

        // Small random weights everywhere
        for (b = 0; b < BEAM; b++) begin
            for (a = 0; a < ANT; a++) begin
                rand_word(w);
                write_weight(1'b0, b, a, w);
                rand_word(w);
                write_weight(1'b1, b, a, w);
            end
        end

        // Isolated pairs, latency and phase products
        for (k = 0; k < 4; k++) begin
            rand_snapshot(xe);
            send(1'b1, xe);
            rand_snapshot(xe);
            send(1'b1, xe);
            send(1'b0, '0);
            send(1'b0, '0);
        end
        wait_results();

        // Back-to-back pairs, several in flight
        for (k = 0; k < 16; k++) begin
            rand_snapshot(xe);
            send(1'b1, xe);
        end
        send(1'b0, '0);
        wait_results();

        // Gaps after an even snapshot
        for (k = 0; k < 8; k++) begin
            rand_snapshot(xe);
            send(k != 1 && k != 5, xe);
        end
        send(1'b0, '0);
        wait_results();

        // One weight at a time between pairs
        for (k = 0; k < 4; k++) begin
            rand_word(w);
            write_weight(k[0], (k / 2) % BEAM, (k * 3) % ANT, w);
            rand_snapshot(xe);
            send(1'b1, xe);
            rand_snapshot(xe);
            send(1'b1, xe);
        end
        send(1'b0, '0);
        wait_results();

        // Full scale, positive clip then a quiet pair
        for (b = 0; b < BEAM; b++) begin
            for (a = 0; a < ANT; a++) begin
                write_weight(1'b0, b, a, W_FULL);
                write_weight(1'b1, b, a, W_FULL);
            end
        end
        send(1'b1, {ANT{W_FULL}});
        send(1'b1, {ANT{W_FULL}});
        send(1'b0, '0);
        send(1'b1, '0);
        send(1'b1, '0);
        send(1'b0, '0);
        wait_results();
        clear_sat();
        send(1'b0, '0);
        send(1'b0, '0);

        // Negative clip, then clear again
        send(1'b1, {ANT{W_NEG}});
        send(1'b1, {ANT{W_NEG}});
        send(1'b0, '0);
        wait_results();
        clear_sat();
        send(1'b0, '0);
        send(1'b1, '0);
        send(1'b1, '0);
        send(1'b0, '0);
        wait_results();
        repeat (4) @(posedge i_clk);

        if (n_out == n_pairs && exp_q.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            report_error($sformatf("%0d results for %0d pairs", n_out, n_pairs));
        end
    end

endmodule

//--- files.f
rtl/beam_pkg.sv
rtl/snapshot_pairer.sv
rtl/codeword_bank.sv
rtl/mac_ants.sv
rtl/mac_beams.sv
rtl/beam_output_stage.sv
rtl/beamformer_top.sv
verification/beamformer_tb.sv

//--- Makefile
TOP := beamformer_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
